// File: logic/cpZero_macros.svh
`ifndef CPZERO_MACROS_SVH
`define CPZERO_MACROS_SVH

// CP0 register numbers, select 0 only
`define REG_BADVADDR 5'd8
`define REG_COUNT    5'd9
`define REG_COMPARE  5'd11
`define REG_STATUS   5'd12
`define REG_CAUSE    5'd13
`define REG_EPC      5'd14
`define REG_PRID     5'd15
`define REG_CONFIG   5'd16

// Cause ExcCode values
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4   // Also used for instruction fetch
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_CPU  5'd11
`define EXC_OV   5'd12
`define EXC_TR   5'd13

// Program counter overrides
`define VECTOR_RESET   32'hBFC0_0000
`define VECTOR_GENERAL 32'h8000_0180   // Normal base plus 0x180 offset

// Read-only register contents
`define PRID_VALUE   32'h0000_0001     // Revision 1, no company or processor id
`define CONFIG_VALUE 32'h8000_0000     // M set, little endian, no MMU

`endif

// File: logic/cpZeroPkg.sv
package cpZeroPkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  regNum_t;    // CP0 register number
    typedef logic [4:0]  excCode_t;   // Cause ExcCode
    typedef logic [7:0]  intVec_t;    // Cause IP or Status IM
    typedef logic [4:0]  hwInt_t;     // External interrupt lines
    typedef logic [3:0]  stageVec_t;  // Bit 0 IF, 1 ID, 2 EX, 3 MEM

    // Raw exception requests from the pipeline
    typedef struct packed {
        logic adIf;   // IF fetch address error
        logic adEl;   // MEM load address error
        logic adEs;   // MEM store address error
        logic ov;     // EX overflow
        logic tr;     // MEM trap
        logic sys;    // ID syscall
        logic bp;     // ID break
        logic ri;     // ID reserved instruction
    } excFlags_t;

    typedef struct packed {
        word_t restartPc;   // Instruction PC, or branch PC in a delay slot
        logic  isBd;
    } stageInfo_t;

    // CP0 instruction in ID
    typedef struct packed {
        logic    mfc0;
        logic    mtc0;
        logic    eret;
        regNum_t rd;
        word_t   wdata;   // GPR value for mtc0
    } cpAccess_t;

    // Exception being taken this cycle
    typedef struct packed {
        logic     take;
        excCode_t code;
        word_t    epc;
        logic     isBd;
        word_t    badAddr;
        logic     loadBadAddr;   // Only address errors update BadVAddr
    } excCommit_t;

    typedef struct packed {
        logic    kernelMode;
        logic    ie;
        logic    exl;
        intVec_t im;
        intVec_t ip;
    } statusView_t;

endpackage

// File: logic/countTimer.sv
module countTimer (
    input  logic             clock,
    input  logic             reset,
    input  logic             countWrite,
    input  logic             compareWrite,
    input  cpZeroPkg::word_t wdata,
    output cpZeroPkg::word_t count,
    output cpZeroPkg::word_t compare,
    output logic             timerPending
);
    import cpZeroPkg::*;

    word_t countNext;
    logic  match;

    // Free running, a write replaces the increment
    assign countNext = countWrite ? wdata : count + 32'd1;
    assign match     = (count == compare);

    always_ff @(posedge clock) begin
        if (reset) begin
            count        <= '0;
            compare      <= '1;     // Far from Count so no match right after reset
            timerPending <= 1'b0;
        end else begin
            count <= countNext;
            if (compareWrite)
                compare <= wdata;
            // Sticky until software rewrites Compare
            if (compareWrite)
                timerPending <= 1'b0;
            else if (match)
                timerPending <= 1'b1;
        end
    end

endmodule

// File: logic/exceptionControl.sv
`include "cpZero_macros.svh"

module exceptionControl (
    input  logic                   clock,
    input  logic                   reset,
    input  cpZeroPkg::cpAccess_t   access,
    input  cpZeroPkg::excFlags_t   exc,
    input  logic                   idStall,      // Blocks every commit
    input  logic                   ifStall,
    input  logic                   idIsFlushed,
    input  cpZeroPkg::stageVec_t   canErr,
    input  cpZeroPkg::stageInfo_t  restartId,
    input  cpZeroPkg::stageInfo_t  restartEx,
    input  cpZeroPkg::stageInfo_t  restartM,
    input  logic                   ifIsBd,
    input  cpZeroPkg::word_t       badAddrM,
    input  cpZeroPkg::word_t       badAddrIf,
    input  cpZeroPkg::statusView_t status,
    input  cpZeroPkg::word_t       epc,
    output cpZeroPkg::excCommit_t  commit,
    output logic                   eretCommit,
    output cpZeroPkg::stageVec_t   excStall,
    output cpZeroPkg::stageVec_t   excFlush,
    output logic                   excPcSel,
    output cpZeroPkg::word_t       excPcOut
);
    import cpZeroPkg::*;

    logic     excCpU;
    logic     excInt;
    logic     ifDetect, idDetect, exDetect, mDetect;
    logic     ifMask, idMask, exMask, mMask;
    logic     ifReady, idReady, exReady, mReady;
    logic     resetQ;
    excCode_t code;

    // Delayed reset, flushes IF on the first cycle out of reset
    always_ff @(posedge clock) begin
        resetQ <= reset;
    end

    // CP0 instructions are kernel only
    assign excCpU = (access.mfc0 | access.mtc0 | access.eret) & ~status.kernelMode;

    // Interrupt enters in ID, never on a flushed slot
    assign excInt = status.ie & (|(status.ip & status.im)) & ~status.exl & ~idIsFlushed;

    // Requests grouped by the stage that raises them
    assign mDetect  = exc.adEl | exc.adEs | exc.tr;
    assign exDetect = exc.ov;
    assign idDetect = exc.sys | exc.bp | exc.ri | excCpU | excInt;
    assign ifDetect = exc.adIf;

    // A stage waits while a forward stage may still fault
    assign mMask  = ifStall;
    assign exMask = ifStall | canErr[3];
    assign idMask = ifStall | canErr[3] | canErr[2];
    assign ifMask = canErr[3] | canErr[2] | canErr[1] | excInt;

    // Stall only when no forward stage is faulting now
    assign excStall[3] = mDetect & mMask;
    assign excStall[2] = exDetect & exMask & ~mDetect;
    assign excStall[1] = (idDetect | access.eret | access.mtc0) & idMask
                         & ~(exDetect | mDetect);   // CP0 writes wait too
    assign excStall[0] = ifDetect & ifMask & ~(idDetect | exDetect | mDetect);

    // Ready stages, forward-most one wins below
    assign mReady  = ~idStall & mDetect & ~mMask;
    assign exReady = ~idStall & exDetect & ~exMask;
    assign idReady = ~idStall & idDetect & ~idMask;
    assign ifReady = ~idStall & ifDetect & ~ifMask;

    assign eretCommit = access.eret & status.kernelMode & ~idStall;

    // Faulting stage and everything behind it become NOPs
    assign excFlush[3] = mDetect;
    assign excFlush[2] = mDetect | exDetect;
    assign excFlush[1] = mDetect | exDetect | idDetect;
    assign excFlush[0] = mDetect | exDetect | idDetect | ifDetect
                         | eretCommit | resetQ;

    // ExcCode by pipeline order, interrupt last
    always_comb begin
        if (exc.adEl)       code = `EXC_ADEL;
        else if (exc.adEs)  code = `EXC_ADES;
        else if (exc.tr)    code = `EXC_TR;
        else if (exc.ov)    code = `EXC_OV;
        else if (exc.sys)   code = `EXC_SYS;
        else if (exc.bp)    code = `EXC_BP;
        else if (exc.ri)    code = `EXC_RI;
        else if (excCpU)    code = `EXC_CPU;
        else if (exc.adIf)  code = `EXC_ADEL;   // Fetch error reports as AdEL
        else                code = `EXC_INT;
    end

    always_comb begin
        commit      = '0;
        commit.take = mReady | exReady | idReady | ifReady;
        commit.code = code;
        if (mReady) begin
            commit.epc         = restartM.restartPc;
            commit.isBd        = restartM.isBd;
            commit.badAddr     = badAddrM;
            commit.loadBadAddr = 1'b1;
        end else if (exReady) begin
            commit.epc  = restartEx.restartPc;
            commit.isBd = restartEx.isBd;
        end else if (idReady) begin
            commit.epc  = restartId.restartPc;
            commit.isBd = restartId.isBd;
        end else if (ifReady) begin
            commit.epc         = badAddrIf;   // Faulting fetch address is the restart point
            commit.isBd        = ifIsBd;
            commit.badAddr     = badAddrIf;
            commit.loadBadAddr = 1'b1;
        end
    end

    assign excPcSel = reset | eretCommit | commit.take;

    always_comb begin
        if (reset)
            excPcOut = `VECTOR_RESET;
        else if (eretCommit)
            excPcOut = epc;              // Return from handler
        else
            excPcOut = `VECTOR_GENERAL;  // All exceptions and interrupts
    end

endmodule

// File: logic/cpZeroRegisters.sv
`include "cpZero_macros.svh"

module cpZeroRegisters (
    input  logic                   clock,
    input  logic                   reset,
    input  cpZeroPkg::cpAccess_t   access,
    input  logic                   idStall,
    input  cpZeroPkg::excCommit_t  commit,
    input  logic                   eretCommit,
    input  cpZeroPkg::hwInt_t      hwInt,
    input  cpZeroPkg::word_t       count,
    input  cpZeroPkg::word_t       compare,
    input  logic                   timerPending,
    output cpZeroPkg::statusView_t status,
    output cpZeroPkg::word_t       epc,
    output cpZeroPkg::word_t       regOut,
    output cpZeroPkg::intVec_t     ip,
    output logic                   kernelMode,
    output logic                   countWrite,
    output logic                   compareWrite,
    output cpZeroPkg::word_t       wdata
);
    import cpZeroPkg::*;

    logic       statusUm;    // 1 for user mode
    logic       statusExl;
    logic       statusIe;
    intVec_t    statusIm;
    logic       causeBd;
    excCode_t   causeCode;
    hwInt_t     causeHwIp;   // IP6..IP2
    logic [1:0] causeSwIp;   // IP1..IP0, software interrupts
    word_t      badVAddr;
    word_t      statusWord;
    word_t      causeWord;
    logic       writeCond;
    logic       writeStatus;
    logic       writeCause;
    logic       writeEpc;

    // Exception level forces kernel mode
    assign kernelMode = ~statusUm | statusExl;

    // mtc0 decode, committed in ID
    assign writeCond    = access.mtc0 & kernelMode & ~idStall;
    assign writeStatus  = writeCond & (access.rd == `REG_STATUS);
    assign writeCause   = writeCond & (access.rd == `REG_CAUSE);
    assign writeEpc     = writeCond & (access.rd == `REG_EPC);
    assign countWrite   = writeCond & (access.rd == `REG_COUNT);
    assign compareWrite = writeCond & (access.rd == `REG_COMPARE);
    assign wdata        = access.wdata;

    assign ip = {timerPending, causeHwIp, causeSwIp};   // IP7 from the timer

    always_comb begin
        status.kernelMode = kernelMode;
        status.ie         = statusIe;
        status.exl        = statusExl;
        status.im         = statusIm;
        status.ip         = ip;
    end

    // Architectural layouts, unused bits read zero
    assign statusWord = {16'h0000, statusIm, 3'b000, statusUm, 2'b00, statusExl, statusIe};
    assign causeWord  = {causeBd, 15'h0000, ip, 1'b0, causeCode, 2'b00};

    // Software-only fields
    always_ff @(posedge clock) begin
        if (reset) begin
            statusUm  <= 1'b0;   // Start in kernel mode
            statusIe  <= 1'b0;
            statusIm  <= '0;
            causeSwIp <= '0;
            causeHwIp <= '0;
        end else begin
            if (writeStatus) begin
                statusUm <= wdata[4];
                statusIe <= wdata[0];
                statusIm <= wdata[15:8];
            end
            if (writeCause)
                causeSwIp <= wdata[9:8];
            causeHwIp <= hwInt;          // Lines sampled every cycle
        end
    end

    // Exception entry overrides mtc0 and ERET
    always_ff @(posedge clock) begin
        if (reset) begin
            statusExl <= 1'b0;
            causeBd   <= 1'b0;
            causeCode <= `EXC_INT;
        end else if (commit.take) begin
            statusExl <= 1'b1;
            causeCode <= commit.code;
            if (!statusExl)
                causeBd <= commit.isBd;  // Nested exception keeps first BD
        end else if (writeStatus) begin
            statusExl <= wdata[1];
        end else if (eretCommit) begin
            statusExl <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (commit.take) begin
            if (!statusExl)
                epc <= commit.epc;       // Keep EPC of the outer exception
        end else if (writeEpc) begin
            epc <= wdata;
        end
        if (commit.take && commit.loadBadAddr)
            badVAddr <= commit.badAddr;
    end

    // mfc0 read path
    always_comb begin
        regOut = '0;
        if (access.mfc0 && kernelMode) begin
            case (access.rd)
                `REG_BADVADDR: regOut = badVAddr;
                `REG_COUNT:    regOut = count;
                `REG_COMPARE:  regOut = compare;
                `REG_STATUS:   regOut = statusWord;
                `REG_CAUSE:    regOut = causeWord;
                `REG_EPC:      regOut = epc;
                `REG_PRID:     regOut = `PRID_VALUE;
                `REG_CONFIG:   regOut = `CONFIG_VALUE;
                default:       regOut = '0;   // Unmapped
            endcase
        end
    end

endmodule

// File: logic/cpZeroUnit.sv
module cpZeroUnit (
    input  logic                   clock,
    input  logic                   reset,
    input  cpZeroPkg::cpAccess_t   access,
    input  logic                   ifStall,
    input  logic                   idStall,
    input  logic                   idIsFlushed,
    input  cpZeroPkg::excFlags_t   exc,
    input  cpZeroPkg::hwInt_t      hwInt,
    input  cpZeroPkg::stageInfo_t  restartId,
    input  cpZeroPkg::stageInfo_t  restartEx,
    input  cpZeroPkg::stageInfo_t  restartM,
    input  logic                   ifIsBd,
    input  cpZeroPkg::word_t       badAddrM,
    input  cpZeroPkg::word_t       badAddrIf,
    input  cpZeroPkg::stageVec_t   canErr,       // Cumulative per stage, IF bit unused
    output cpZeroPkg::word_t       regOut,
    output logic                   kernelMode,
    output cpZeroPkg::stageVec_t   excStall,
    output cpZeroPkg::stageVec_t   excFlush,
    output logic                   excPcSel,
    output cpZeroPkg::word_t       excPcOut,
    output cpZeroPkg::intVec_t     ip
);
    import cpZeroPkg::*;

    excCommit_t  commit;
    logic        eretCommit;
    statusView_t status;
    word_t       epc;
    logic        countWrite;
    logic        compareWrite;
    word_t       wdata;
    word_t       count;
    word_t       compare;
    logic        timerPending;

    // Detection, priority and PC override
    exceptionControl exceptionControl_i (
        .clock      (clock),
        .reset      (reset),
        .access     (access),
        .exc        (exc),
        .idStall    (idStall),
        .ifStall    (ifStall),
        .idIsFlushed(idIsFlushed),
        .canErr     (canErr),
        .restartId  (restartId),
        .restartEx  (restartEx),
        .restartM   (restartM),
        .ifIsBd     (ifIsBd),
        .badAddrM   (badAddrM),
        .badAddrIf  (badAddrIf),
        .status     (status),
        .epc        (epc),
        .commit     (commit),
        .eretCommit (eretCommit),
        .excStall   (excStall),
        .excFlush   (excFlush),
        .excPcSel   (excPcSel),
        .excPcOut   (excPcOut)
    );

    // Architectural state and mfc0 reads
    cpZeroRegisters cpZeroRegisters_i (
        .clock       (clock),
        .reset       (reset),
        .access      (access),
        .idStall     (idStall),
        .commit      (commit),
        .eretCommit  (eretCommit),
        .hwInt       (hwInt),
        .count       (count),
        .compare     (compare),
        .timerPending(timerPending),
        .status      (status),
        .epc         (epc),
        .regOut      (regOut),
        .ip          (ip),
        .kernelMode  (kernelMode),
        .countWrite  (countWrite),
        .compareWrite(compareWrite),
        .wdata       (wdata)
    );

    countTimer countTimer_i (
        .clock       (clock),
        .reset       (reset),
        .countWrite  (countWrite),
        .compareWrite(compareWrite),
        .wdata       (wdata),
        .count       (count),
        .compare     (compare),
        .timerPending(timerPending)   // Becomes Cause IP7
    );

endmodule

// File: test/cpZeroChecker.sv
`include "cpZero_macros.svh"

module cpZeroChecker (
    input  logic                 clock,
    input  logic                 valid,      // Line in flight this cycle
    input  logic                 finished,
    input  int                   testNum,
    input  cpZeroPkg::cpAccess_t access,     // Access in ID, for the derived checks
    input  cpZeroPkg::excFlags_t exc,
    input  cpZeroPkg::word_t     expReg,
    input  cpZeroPkg::stageVec_t expStall,
    input  cpZeroPkg::stageVec_t expFlush,
    input  logic                 expSel,
    input  cpZeroPkg::word_t     expPc,
    input  logic [4:0]           expMask,
    input  cpZeroPkg::word_t     regOut,
    input  cpZeroPkg::stageVec_t excStall,
    input  cpZeroPkg::stageVec_t excFlush,
    input  logic                 excPcSel,
    input  cpZeroPkg::word_t     excPcOut,
    input  logic                 kernelMode,
    input  cpZeroPkg::intVec_t   ip,
    output int                   errorCount
);
    timeunit 1ns;
    timeprecision 1ps;

    import cpZeroPkg::*;

    int lastTest   = -1;
    int testErrors = 0;
    int passCount  = 0;
    int failCount  = 0;

    initial errorCount = 0;

    task automatic compareField(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("[ERROR] time %0d ns: test %0d %s is %h, expected %h",
                     $time, testNum, name, got, want);
            errorCount++;
            testErrors++;
        end
    endtask

    // Only a user-mode mfc0 reads zero and flushes ID with no request raised
    function automatic logic expectedKernelMode();
        logic raised;
        raised = exc.adEl | exc.adEs | exc.ov | exc.tr | exc.sys | exc.bp | exc.ri;
        return !(expFlush[1] && !raised && expReg == '0);
    endfunction

    // One line per finished test
    task automatic reportTest();
        if (lastTest >= 0) begin
            if (testErrors == 0) begin
                $display("Test %0d passed", lastTest);
                passCount++;
            end else begin
                $display("Test %0d failed with %0d mismatches", lastTest, testErrors);
                failCount++;
            end
        end
    endtask

    // Sample 1 ns before the next rising edge
    always begin
        @(posedge clock);
        #7;
        if (valid) begin
            if (testNum != lastTest) begin
                reportTest();
                lastTest   = testNum;
                testErrors = 0;
            end
            if (expMask[0]) compareField("regOut", regOut, expReg);
            if (expMask[1]) compareField("excStall", word_t'(excStall), word_t'(expStall));
            if (expMask[2]) compareField("excFlush", word_t'(excFlush), word_t'(expFlush));
            if (expMask[3]) compareField("excPcSel", word_t'(excPcSel), word_t'(expSel));
            if (expMask[4]) compareField("excPcOut", excPcOut, expPc);
            // Mode follows from the read result, IP from the Cause field
            if (expMask[0] && expMask[2] && access.mfc0) begin
                compareField("kernelMode", word_t'(kernelMode),
                             word_t'(expectedKernelMode()));
                if (access.rd == `REG_CAUSE && expectedKernelMode())
                    compareField("ip", word_t'(ip), word_t'(expReg[15:8]));
            end
        end
    end

    always @(posedge finished) begin
        reportTest();
        $display("Tests passed %0d, failed %0d, mismatches %0d",
                 passCount, failCount, errorCount);
    end

endmodule

// File: test/cpZeroUnitTb.sv
module cpZeroUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpZeroPkg::*;

    localparam int ResetWaitLimit = 20;    // Cycles allowed for reset release
    localparam int LineLimit      = 200;   // Data lines allowed before giving up

    logic        clock;
    logic        reset;
    cpAccess_t   access;
    logic        ifStall;
    logic        idStall;
    logic        idIsFlushed;
    excFlags_t   exc;
    hwInt_t      hwInt;
    stageInfo_t  restartId;
    stageInfo_t  restartEx;
    stageInfo_t  restartM;
    logic        ifIsBd;
    word_t       badAddrM;
    word_t       badAddrIf;
    stageVec_t   canErr;
    word_t       regOut;
    logic        kernelMode;
    stageVec_t   excStall;
    stageVec_t   excFlush;
    logic        excPcSel;
    word_t       excPcOut;
    intVec_t     ip;

    // Expected columns handed to the checker
    int          testNum;
    word_t       expReg;
    stageVec_t   expStall;
    stageVec_t   expFlush;
    logic        expSel;
    word_t       expPc;
    logic [4:0]  expMask;    // Bit 0 regOut, 1 stall, 2 flush, 3 pcSel, 4 pcOut
    logic        valid;
    logic        finished;
    int          errorCount;
    logic [31:0] col [27];   // One parsed data line

    always #4 clock = ~clock;

    cpZeroUnit cpZeroUnit_i (
        .clock      (clock),
        .reset      (reset),
        .access     (access),
        .ifStall    (ifStall),
        .idStall    (idStall),
        .idIsFlushed(idIsFlushed),
        .exc        (exc),
        .hwInt      (hwInt),
        .restartId  (restartId),
        .restartEx  (restartEx),
        .restartM   (restartM),
        .ifIsBd     (ifIsBd),
        .badAddrM   (badAddrM),
        .badAddrIf  (badAddrIf),
        .canErr     (canErr),
        .regOut     (regOut),
        .kernelMode (kernelMode),
        .excStall   (excStall),
        .excFlush   (excFlush),
        .excPcSel   (excPcSel),
        .excPcOut   (excPcOut),
        .ip         (ip)
    );

    cpZeroChecker cpZeroChecker_i (
        .clock     (clock),
        .valid     (valid),
        .finished  (finished),
        .testNum   (testNum),
        .access    (access),
        .exc       (exc),
        .expReg    (expReg),
        .expStall  (expStall),
        .expFlush  (expFlush),
        .expSel    (expSel),
        .expPc     (expPc),
        .expMask   (expMask),
        .regOut    (regOut),
        .excStall  (excStall),
        .excFlush  (excFlush),
        .excPcSel  (excPcSel),
        .excPcOut  (excPcOut),
        .kernelMode(kernelMode),
        .ip        (ip),
        .errorCount(errorCount)
    );

    // Reset held over two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
    end

    // Copy one parsed line onto the DUT inputs and expected columns
    task automatic applyLine();
        testNum           = col[0];
        access.mfc0       = col[1][0];
        access.mtc0       = col[2][0];
        access.eret       = col[3][0];
        access.rd         = col[4][4:0];
        access.wdata      = col[5];
        ifStall           = col[6][0];
        idStall           = col[7][0];
        idIsFlushed       = col[8][0];
        exc               = col[9][7:0];   // adIf in bit 7 down to ri in bit 0
        hwInt             = col[10][4:0];
        restartId.restartPc = col[11];
        restartId.isBd    = col[12][0];
        restartEx.restartPc = col[13];
        restartEx.isBd    = col[14][0];
        restartM.restartPc  = col[15];
        restartM.isBd     = col[16][0];
        ifIsBd            = col[17][0];
        badAddrM          = col[18];
        badAddrIf         = col[19];
        canErr            = col[20][3:0];
        expReg            = col[21];
        expStall          = col[22][3:0];
        expFlush          = col[23][3:0];
        expSel            = col[24][0];
        expPc             = col[25];
        expMask           = col[26][4:0];
    endtask

    initial begin : stimulus
        int    fd;
        int    n;
        int    waits;
        int    lines;
        bit    failed;
        string line;

        clock       = 1'b0;
        access      = '0;
        ifStall     = 1'b0;
        idStall     = 1'b0;
        idIsFlushed = 1'b0;
        exc         = '0;
        hwInt       = '0;
        restartId   = '0;
        restartEx   = '0;
        restartM    = '0;
        ifIsBd      = 1'b0;
        badAddrM    = '0;
        badAddrIf   = '0;
        canErr      = '0;
        testNum     = 0;
        expReg      = '0;
        expStall    = '0;
        expFlush    = '0;
        expSel      = 1'b0;
        expPc       = '0;
        expMask     = '0;
        valid       = 1'b0;
        finished    = 1'b0;
        failed      = 1'b0;

        fd = $fopen("test/cpZero_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            failed = 1'b1;
        end

        waits = 0;
        while (!failed && reset !== 1'b0) begin
            @(posedge clock);
            waits++;
            if (waits > ResetWaitLimit) begin
                $display("Timeout while waiting for reset release");
                failed = 1'b1;
            end
        end

        // One data line per clock cycle, comments and blanks cost no cycle
        lines = 0;
        while (!failed && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != 8'h23) begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                    col[9], col[10], col[11], col[12], col[13], col[14], col[15], col[16],
                    col[17], col[18], col[19], col[20], col[21], col[22], col[23], col[24],
                    col[25], col[26]);
                if (n == 27) begin
                    #1;              // Drive just after the edge
                    applyLine();
                    valid = 1'b1;
                    @(posedge clock);
                    lines++;
                    if (lines > LineLimit) begin
                        $display("Timeout while reading the test data file");
                        failed = 1'b1;
                    end
                end
            end
        end

        #1 valid = 1'b0;
        access   = '0;
        exc      = '0;
        @(posedge clock);
        finished = 1'b1;
        #1;
        if (failed || errorCount != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

// File: test/cpZero_testdata.txt
# test mfc0 mtc0 eret rd wdata ifStall idStall idFlushed exc hwInt idPc idBd exPc exBd mPc mBd
# ifIsBd badM badIf canErr | expRegOut expStall expFlush expPcSel expPcOut mask(out,stall,flush,sel,pc)
1 0 1 0 c 401 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
1 1 0 0 c 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 401 0 0 0 0 0f
1 0 1 0 e abc000 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
1 1 0 0 e 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 abc000 0 0 0 0 0f
1 1 0 0 f 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 1 0 0 0 0 0f
1 1 0 0 10 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 80000000 0 0 0 0 0f
1 1 0 0 3 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
1 0 1 0 c 411 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
1 1 0 0 c 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 3 1 80000180 1f
1 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 2c 0 0 0 0 0f
1 1 0 0 e 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 100 0 0 0 0 0f
1 0 1 0 c 401 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
2 0 1 0 9 1000 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
2 1 0 0 9 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 1000 0 0 0 0 0f
2 0 0 0 0 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0e
2 0 0 0 0 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0e
2 1 0 0 9 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 1003 0 0 0 0 0f
3 0 0 0 0 0 0 0 0 44 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 f 1 80000180 1f
3 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 10 0 0 0 0 0f
3 1 0 0 e 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 300 0 0 0 0 0f
3 1 0 0 8 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 dead0 0 0 0 0 0f
3 0 1 0 c 401 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
4 0 0 0 0 0 0 0 0 04 0 100 0 200 0 300 0 0 dead0 5678 4 0 2 3 0 0 0f
4 1 0 0 d 0 0 0 0 04 0 100 0 200 0 300 0 0 dead0 5678 4 10 2 3 0 0 0f
4 1 0 0 c 0 0 0 0 04 0 100 0 200 0 300 0 0 dead0 5678 4 401 2 3 0 0 0f
4 0 0 0 0 0 0 0 0 04 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 3 1 80000180 1f
4 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 20 0 0 0 0 0f
4 0 1 0 c 401 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
5 0 0 0 0 0 0 0 0 00 1 140 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
5 0 0 0 0 0 0 0 0 00 1 140 0 200 0 300 0 0 dead0 5678 0 0 0 3 1 80000180 1f
5 1 0 0 e 0 0 0 0 00 0 140 0 200 0 300 0 0 dead0 5678 0 140 0 0 0 0 0f
5 1 0 0 c 0 0 0 0 00 0 140 0 200 0 300 0 0 dead0 5678 0 403 0 0 0 0 0f
5 0 0 1 0 0 0 0 0 00 0 140 0 200 0 300 0 0 dead0 5678 0 0 0 1 1 140 1f
5 1 0 0 c 0 0 0 0 00 0 140 0 200 0 300 0 0 dead0 5678 0 401 0 0 0 0 0f
6 0 1 0 b 101a 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
6 1 0 0 b 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 101a 0 0 0 0 0f
6 0 0 0 0 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0e
6 0 0 0 0 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0e
6 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
6 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
6 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 8000 0 0 0 0 0f
6 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 8000 0 0 0 0 0f
6 0 1 0 b 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f
6 1 0 0 d 0 0 0 0 00 0 100 0 200 0 300 0 0 dead0 5678 0 0 0 0 0 0 0f

// File: flist.f
+incdir+logic
logic/cpZeroPkg.sv
logic/countTimer.sv
logic/exceptionControl.sv
logic/cpZeroRegisters.sv
logic/cpZeroUnit.sv
test/cpZeroChecker.sv
test/cpZeroUnitTb.sv
